/* hw/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  regsel_t;
	typedef logic [4:0]  alu_op_t;
	typedef logic [1:0]  reg_dst_t;

	// write register select
	localparam reg_dst_t dst_rd = 2'd0;
	localparam reg_dst_t dst_rt = 2'd1;
	localparam reg_dst_t dst_ra = 2'd2; // $31 for links

	localparam opcode_t op_rtype  = 6'b000000;
	localparam opcode_t op_regimm = 6'b000001;
	localparam opcode_t op_j      = 6'b000010;
	localparam opcode_t op_jal    = 6'b000011;
	localparam opcode_t op_beq    = 6'b000100;
	localparam opcode_t op_bne    = 6'b000101;
	localparam opcode_t op_blez   = 6'b000110;
	localparam opcode_t op_bgtz   = 6'b000111;
	localparam opcode_t op_addi   = 6'b001000;
	localparam opcode_t op_addiu  = 6'b001001;
	localparam opcode_t op_slti   = 6'b001010;
	localparam opcode_t op_sltiu  = 6'b001011;
	localparam opcode_t op_andi   = 6'b001100;
	localparam opcode_t op_ori    = 6'b001101;
	localparam opcode_t op_xori   = 6'b001110;
	localparam opcode_t op_lui    = 6'b001111;
	localparam opcode_t op_cop0   = 6'b010000;
	localparam opcode_t op_lb     = 6'b100000;
	localparam opcode_t op_lh     = 6'b100001;
	localparam opcode_t op_lw     = 6'b100011;
	localparam opcode_t op_lbu    = 6'b100100;
	localparam opcode_t op_lhu    = 6'b100101;
	localparam opcode_t op_sb     = 6'b101000;
	localparam opcode_t op_sh     = 6'b101001;
	localparam opcode_t op_sw     = 6'b101011;

	localparam funct_t fn_sll     = 6'b000000;
	localparam funct_t fn_srl     = 6'b000010;
	localparam funct_t fn_sra     = 6'b000011;
	localparam funct_t fn_sllv    = 6'b000100;
	localparam funct_t fn_srlv    = 6'b000110;
	localparam funct_t fn_srav    = 6'b000111;
	localparam funct_t fn_jr      = 6'b001000;
	localparam funct_t fn_jalr    = 6'b001001;
	localparam funct_t fn_syscall = 6'b001100;
	localparam funct_t fn_break   = 6'b001101;
	localparam funct_t fn_mfhi    = 6'b010000;
	localparam funct_t fn_mthi    = 6'b010001;
	localparam funct_t fn_mflo    = 6'b010010;
	localparam funct_t fn_mtlo    = 6'b010011;
	localparam funct_t fn_mult    = 6'b011000;
	localparam funct_t fn_multu   = 6'b011001;
	localparam funct_t fn_div     = 6'b011010;
	localparam funct_t fn_divu    = 6'b011011;
	localparam funct_t fn_add     = 6'b100000;
	localparam funct_t fn_addu    = 6'b100001;
	localparam funct_t fn_sub     = 6'b100010;
	localparam funct_t fn_subu    = 6'b100011;
	localparam funct_t fn_and     = 6'b100100;
	localparam funct_t fn_or      = 6'b100101;
	localparam funct_t fn_xor     = 6'b100110;
	localparam funct_t fn_nor     = 6'b100111;
	localparam funct_t fn_slt     = 6'b101010;
	localparam funct_t fn_sltu    = 6'b101011;

	localparam regsel_t rs_mfc0 = 5'b00000;
	localparam regsel_t rs_mtc0 = 5'b00100;

	localparam instr_t eret_word = 32'h4200_0018;

	// alu_nop has to stay zero, a flushed stage reads as nop
	localparam alu_op_t alu_nop   = 5'd0;
	localparam alu_op_t alu_add   = 5'd1;
	localparam alu_op_t alu_addu  = 5'd2;
	localparam alu_op_t alu_sub   = 5'd3;
	localparam alu_op_t alu_subu  = 5'd4;
	localparam alu_op_t alu_and   = 5'd5;
	localparam alu_op_t alu_or    = 5'd6;
	localparam alu_op_t alu_xor   = 5'd7;
	localparam alu_op_t alu_nor   = 5'd8;
	localparam alu_op_t alu_slt   = 5'd9;
	localparam alu_op_t alu_sltu  = 5'd10;
	localparam alu_op_t alu_sll   = 5'd11;
	localparam alu_op_t alu_srl   = 5'd12;
	localparam alu_op_t alu_sra   = 5'd13;
	localparam alu_op_t alu_lui   = 5'd14;
	localparam alu_op_t alu_sllv  = 5'd15;
	localparam alu_op_t alu_srlv  = 5'd16;
	localparam alu_op_t alu_srav  = 5'd17;
	localparam alu_op_t alu_mult  = 5'd18;
	localparam alu_op_t alu_multu = 5'd19;
	localparam alu_op_t alu_div   = 5'd20;
	localparam alu_op_t alu_divu  = 5'd21;

	// cp0 cause codes, eret is local to this core
	localparam int unsigned exc_none = 0;
	localparam int unsigned exc_sys  = 8;
	localparam int unsigned exc_bp   = 9;
	localparam int unsigned exc_ri   = 10;
	localparam int unsigned exc_eret = 14;

	typedef struct packed {
		reg_dst_t reg_dst;
		logic     alu_imm_sel; // srcb from immediate
		logic     hilo_wen;
	} ex_ctrl_t;

	typedef struct packed {
		logic reg_write_en;
		logic mem_read_en;
		logic mem_write_en;
		logic mem_to_reg;
		logic hilo_to_reg;
		logic cp0_wen;
		logic cp0_to_reg;
		logic ri;
		logic brk;
		logic syscall;
		logic eret;
	} mem_ctrl_t;

endpackage

/* hw/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder
	import mips_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  instr_t    instr,
	input  logic      stall_e,
	input  logic      stall_m,
	input  logic      flush_e,
	input  logic      flush_m,
	output logic      sign_ext,
	output ex_ctrl_t  ctrl_e,
	output mem_ctrl_t ctrl_e_mem,
	output mem_ctrl_t ctrl_m
);

	opcode_t   opcode;
	regsel_t   rs;
	regsel_t   rt;
	funct_t    funct;
	ex_ctrl_t  ex_d;
	mem_ctrl_t mem_d;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign funct  = instr[5:0];

	// andi ori xori lui are zero extended
	assign sign_ext = (opcode[5:2] != 4'b0011);

	always_comb begin
		ex_d  = '0;
		mem_d = '0;
		case (opcode)
			op_rtype: begin
				case (funct)
					fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
					fn_and, fn_or, fn_xor, fn_nor,
					fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav: begin
						mem_d.reg_write_en = 1'b1;
					end
					fn_mfhi, fn_mflo: begin
						mem_d.reg_write_en = 1'b1;
						mem_d.hilo_to_reg  = 1'b1;
					end
					fn_mult, fn_multu, fn_div, fn_divu, fn_mthi, fn_mtlo: begin
						ex_d.hilo_wen = 1'b1;
					end
					fn_jr: begin
						// nothing written, target handled in decode
					end
					fn_jalr: begin
						mem_d.reg_write_en = 1'b1;
						ex_d.reg_dst       = dst_ra; // rd field ignored
					end
					fn_syscall: begin
						mem_d.syscall = 1'b1;
					end
					fn_break: begin
						mem_d.brk = 1'b1;
					end
					default: begin
						mem_d.ri = 1'b1;
					end
				endcase
			end

			op_addi, op_addiu, op_slti, op_sltiu,
			op_andi, op_ori, op_xori, op_lui: begin
				mem_d.reg_write_en = 1'b1;
				ex_d.reg_dst       = dst_rt;
				ex_d.alu_imm_sel   = 1'b1;
			end

			op_beq, op_bne, op_blez, op_bgtz: begin
				// compare only
			end

			op_regimm: begin
				case (rt[4:1])
					4'b1000: begin // bltzal bgezal
						mem_d.reg_write_en = 1'b1;
						ex_d.reg_dst       = dst_ra;
					end
					4'b0000: begin // bltz bgez
					end
					default: begin
						mem_d.ri = 1'b1;
					end
				endcase
			end

			op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
				mem_d.reg_write_en = 1'b1;
				mem_d.mem_read_en  = 1'b1;
				mem_d.mem_to_reg   = 1'b1;
				ex_d.reg_dst       = dst_rt;
				ex_d.alu_imm_sel   = 1'b1;
			end

			op_sb, op_sh, op_sw: begin
				mem_d.mem_write_en = 1'b1;
				ex_d.alu_imm_sel   = 1'b1; // address = base + offset
			end

			op_j: begin
			end

			op_jal: begin
				mem_d.reg_write_en = 1'b1;
				ex_d.reg_dst       = dst_ra;
			end

			op_cop0: begin
				case (rs)
					rs_mtc0: begin
						mem_d.cp0_wen = 1'b1;
					end
					rs_mfc0: begin
						mem_d.reg_write_en = 1'b1;
						mem_d.cp0_to_reg   = 1'b1;
						ex_d.reg_dst       = dst_rt;
					end
					default: begin
						// only eret is legal here, and only the exact word
						mem_d.eret = (instr == eret_word);
						mem_d.ri   = (instr != eret_word);
					end
				endcase
			end

			default: begin
				mem_d.ri = 1'b1;
			end
		endcase
	end

	// id/ex
	always_ff @(posedge clk) begin
		if (!rst_n || flush_e) begin
			ctrl_e     <= '0;
			ctrl_e_mem <= '0;
		end else if (!stall_e) begin
			ctrl_e     <= ex_d;
			ctrl_e_mem <= mem_d;
		end
	end

	// ex/mem, loads from execute even when execute holds
	always_ff @(posedge clk) begin
		if (!rst_n || flush_m) begin
			ctrl_m <= '0;
		end else if (!stall_m) begin
			ctrl_m <= ctrl_e_mem;
		end
	end

endmodule

/* hw/alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder
	import mips_ctrl_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  instr_t  instr,
	input  logic    stall_e,
	input  logic    flush_e,
	output alu_op_t alu_op_e
);

	opcode_t opcode;
	funct_t  funct;
	alu_op_t alu_op_d;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		alu_op_d = alu_nop;
		case (opcode)
			op_rtype: begin
				case (funct)
					fn_add:   alu_op_d = alu_add;
					fn_addu:  alu_op_d = alu_addu;
					fn_sub:   alu_op_d = alu_sub;
					fn_subu:  alu_op_d = alu_subu;
					fn_and:   alu_op_d = alu_and;
					fn_or:    alu_op_d = alu_or;
					fn_xor:   alu_op_d = alu_xor;
					fn_nor:   alu_op_d = alu_nor;
					fn_slt:   alu_op_d = alu_slt;
					fn_sltu:  alu_op_d = alu_sltu;
					fn_sll:   alu_op_d = alu_sll;
					fn_srl:   alu_op_d = alu_srl;
					fn_sra:   alu_op_d = alu_sra;
					fn_sllv:  alu_op_d = alu_sllv;
					fn_srlv:  alu_op_d = alu_srlv;
					fn_srav:  alu_op_d = alu_srav;
					fn_mult:  alu_op_d = alu_mult;
					fn_multu: alu_op_d = alu_multu;
					fn_div:   alu_op_d = alu_div;
					fn_divu:  alu_op_d = alu_divu;
					default:  alu_op_d = alu_nop; // jumps, hi/lo moves, traps
				endcase
			end

			op_addi:  alu_op_d = alu_add;
			op_addiu: alu_op_d = alu_addu;
			op_slti:  alu_op_d = alu_slt;
			op_sltiu: alu_op_d = alu_sltu;
			op_andi:  alu_op_d = alu_and;
			op_ori:   alu_op_d = alu_or;
			op_xori:  alu_op_d = alu_xor;
			op_lui:   alu_op_d = alu_lui;

			// effective address
			op_lb, op_lbu, op_lh, op_lhu, op_lw,
			op_sb, op_sh, op_sw: begin
				alu_op_d = alu_addu;
			end

			op_beq, op_bne, op_blez, op_bgtz, op_regimm: begin
				alu_op_d = alu_subu;
			end

			default: alu_op_d = alu_nop;
		endcase
	end

	// same hold and bubble rule as the id/ex control register
	always_ff @(posedge clk) begin
		if (!rst_n || flush_e) begin
			alu_op_e <= alu_nop;
		end else if (!stall_e) begin
			alu_op_e <= alu_op_d;
		end
	end

endmodule

/* hw/exc_encoder.sv */
`timescale 1ns/1ps

module exc_encoder
	import mips_ctrl_pkg::*;
#(
	parameter int exc_code_width = 5
) (
	input  mem_ctrl_t                 ctrl_m,
	output logic [exc_code_width-1:0] exc_code,
	output logic                      exc_pending
);

	localparam logic [exc_code_width-1:0] code_none = exc_code_width'(exc_none);
	localparam logic [exc_code_width-1:0] code_ri   = exc_code_width'(exc_ri);
	localparam logic [exc_code_width-1:0] code_sys  = exc_code_width'(exc_sys);
	localparam logic [exc_code_width-1:0] code_bp   = exc_code_width'(exc_bp);
	localparam logic [exc_code_width-1:0] code_eret = exc_code_width'(exc_eret);

	assign exc_pending = ctrl_m.ri | ctrl_m.syscall | ctrl_m.brk | ctrl_m.eret;

	// ri first, eret last
	always_comb begin
		if (ctrl_m.ri) begin
			exc_code = code_ri;
		end else if (ctrl_m.syscall) begin
			exc_code = code_sys;
		end else if (ctrl_m.brk) begin
			exc_code = code_bp;
		end else if (ctrl_m.eret) begin
			exc_code = code_eret;
		end else begin
			exc_code = code_none;
		end
	end

endmodule

/* hw/ctrl_unit.sv */
`timescale 1ns/1ps

module ctrl_unit
	import mips_ctrl_pkg::*;
#(
	parameter int exc_code_width = 5
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  instr_t                    instr,
	input  logic                      stall_e,
	input  logic                      stall_m,
	input  logic                      flush_e,
	input  logic                      flush_m,
	output logic                      sign_ext,
	output ex_ctrl_t                  ctrl_e,
	output mem_ctrl_t                 ctrl_e_mem,
	output alu_op_t                   alu_op_e,
	output mem_ctrl_t                 ctrl_m,
	output logic [exc_code_width-1:0] exc_code,
	output logic                      exc_pending
);

	main_decoder u_main_dec (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.stall_e    (stall_e),
		.stall_m    (stall_m),
		.flush_e    (flush_e),
		.flush_m    (flush_m),
		.sign_ext   (sign_ext),
		.ctrl_e     (ctrl_e),
		.ctrl_e_mem (ctrl_e_mem),
		.ctrl_m     (ctrl_m)
	);

	alu_decoder u_alu_dec (
		.clk      (clk),
		.rst_n    (rst_n),
		.instr    (instr),
		.stall_e  (stall_e),
		.flush_e  (flush_e),
		.alu_op_e (alu_op_e)
	);

	// memory stage flags to cp0
	exc_encoder #(
		.exc_code_width (exc_code_width)
	) u_exc_enc (
		.ctrl_m      (ctrl_m),
		.exc_code    (exc_code),
		.exc_pending (exc_pending)
	);

endmodule

/* tb/ctrl_vectors.svh */
// columns: instr, sign_ext, ex {reg_dst, alu_imm_sel, hilo_wen}, mem flags, alu op, exc code
// mem flags: reg_wr mem_rd mem_wr mem2reg _ hilo2reg cp0_wen cp0_2reg _ ri brk sys eret

localparam int r_add    = 0;
localparam int r_addi   = 7;
localparam int r_lw     = 14;
localparam int r_mtc0   = 18;
localparam int r_eret   = 20;
localparam int r_sys    = 21;

task automatic load_table();
	// r-type
	add_row(32'h0022_1820, 1'b1, 4'b00_0_0, 11'b1000_000_0000, alu_add,  exc_none);
	add_row(32'h0001_1100, 1'b1, 4'b00_0_0, 11'b1000_000_0000, alu_sll,  exc_none);
	add_row(32'h03e0_0008, 1'b1, 4'b00_0_0, 11'b0000_000_0000, alu_nop,  exc_none); // jr
	add_row(32'h0080_f809, 1'b1, 4'b10_0_0, 11'b1000_000_0000, alu_nop,  exc_none); // jalr
	add_row(32'h0022_0018, 1'b1, 4'b00_0_1, 11'b0000_000_0000, alu_mult, exc_none);
	add_row(32'h0000_2810, 1'b1, 4'b00_0_0, 11'b1000_100_0000, alu_nop,  exc_none); // mfhi
	add_row(32'h00c0_0011, 1'b1, 4'b00_0_1, 11'b0000_000_0000, alu_nop,  exc_none); // mthi

	// immediates, andi and lui zero extend
	add_row(32'h2022_ffff, 1'b1, 4'b01_1_0, 11'b1000_000_0000, alu_add,  exc_none);
	add_row(32'h3022_00ff, 1'b0, 4'b01_1_0, 11'b1000_000_0000, alu_and,  exc_none);
	add_row(32'h3c03_1234, 1'b0, 4'b01_1_0, 11'b1000_000_0000, alu_lui,  exc_none);

	// branches
	add_row(32'h1022_0004, 1'b1, 4'b00_0_0, 11'b0000_000_0000, alu_subu, exc_none); // beq
	add_row(32'h0430_0008, 1'b1, 4'b10_0_0, 11'b1000_000_0000, alu_subu, exc_none); // bltzal
	add_row(32'h0421_0008, 1'b1, 4'b00_0_0, 11'b0000_000_0000, alu_subu, exc_none); // bgez
	add_row(32'h0425_0008, 1'b1, 4'b00_0_0, 11'b0000_000_1000, alu_subu, exc_ri);   // bad rt

	// memory
	add_row(32'h8c22_0008, 1'b1, 4'b01_1_0, 11'b1101_000_0000, alu_addu, exc_none);
	add_row(32'hac22_0008, 1'b1, 4'b00_1_0, 11'b0010_000_0000, alu_addu, exc_none);

	// jumps
	add_row(32'h0800_0100, 1'b1, 4'b00_0_0, 11'b0000_000_0000, alu_nop,  exc_none);
	add_row(32'h0c00_0100, 1'b1, 4'b10_0_0, 11'b1000_000_0000, alu_nop,  exc_none);

	// cop0
	add_row(32'h4082_6000, 1'b1, 4'b00_0_0, 11'b0000_010_0000, alu_nop,  exc_none); // mtc0
	add_row(32'h4002_6000, 1'b1, 4'b01_0_0, 11'b1000_001_0000, alu_nop,  exc_none); // mfc0
	add_row(32'h4200_0018, 1'b1, 4'b00_0_0, 11'b0000_000_0001, alu_nop,  exc_eret);

	// traps and reserved words
	add_row(32'h0000_000c, 1'b1, 4'b00_0_0, 11'b0000_000_0010, alu_nop,  exc_sys);
	add_row(32'h0000_000d, 1'b1, 4'b00_0_0, 11'b0000_000_0100, alu_nop,  exc_bp);
	add_row(32'h0000_003f, 1'b1, 4'b00_0_0, 11'b0000_000_1000, alu_nop,  exc_ri);   // funct
	add_row(32'hfc00_0000, 1'b1, 4'b00_0_0, 11'b0000_000_1000, alu_nop,  exc_ri);   // opcode
	add_row(32'h4200_0019, 1'b1, 4'b00_0_0, 11'b0000_000_1000, alu_nop,  exc_ri);   // not eret
endtask

/* tb/tb_ctrl_unit.sv */
`timescale 1ns/1ps

module tb_ctrl_unit
	import mips_ctrl_pkg::*;
();

	localparam int exc_w    = 5;
	localparam int max_rows = 32;

	logic              clk = 1'b0;
	logic              rst_n;
	instr_t            instr;
	logic              stall_e;
	logic              stall_m;
	logic              flush_e;
	logic              flush_m;
	logic              sign_ext;
	ex_ctrl_t          ctrl_e;
	mem_ctrl_t         ctrl_e_mem;
	alu_op_t           alu_op_e;
	mem_ctrl_t         ctrl_m;
	logic [exc_w-1:0]  exc_code;
	logic              exc_pending;

	instr_t      vec_instr [max_rows];
	logic        vec_sext  [max_rows];
	ex_ctrl_t    vec_ex    [max_rows];
	mem_ctrl_t   vec_mem   [max_rows];
	alu_op_t     vec_alu   [max_rows];
	int unsigned vec_exc   [max_rows];
	int          n_rows = 0;
	int          seq [64];
	int          seq_len;
	logic [15:0] lfsr;

	ctrl_unit #(
		.exc_code_width (exc_w)
	) dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.stall_e     (stall_e),
		.stall_m     (stall_m),
		.flush_e     (flush_e),
		.flush_m     (flush_m),
		.sign_ext    (sign_ext),
		.ctrl_e      (ctrl_e),
		.ctrl_e_mem  (ctrl_e_mem),
		.alu_op_e    (alu_op_e),
		.ctrl_m      (ctrl_m),
		.exc_code    (exc_code),
		.exc_pending (exc_pending)
	);

	always #5 clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	task automatic add_row(input instr_t w, input logic se, input logic [3:0] ex,
			input logic [10:0] mem, input alu_op_t op, input int unsigned exc);
		vec_instr[n_rows] = w;
		vec_sext[n_rows]  = se;
		vec_ex[n_rows]    = ex;
		vec_mem[n_rows]   = mem;
		vec_alu[n_rows]   = op;
		vec_exc[n_rows]   = exc;
		n_rows++;
	endtask

	`include "ctrl_vectors.svh"

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "value check failed");
		end
	endtask

	// galois taps x^16 x^14 x^13 x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hb400;
		return n;
	endfunction

	task automatic pick_row(output int idx);
		logic [4:0] bits;
		int b;
		bits = '0;
		for (b = 0; b < 5; b++) begin
			bits = {bits[3:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		idx = int'(bits) % n_rows;
	endtask

	task automatic check_exec(input int r);
		check("ctrl_e", ctrl_e, vec_ex[r]);
		check("ctrl_e_mem", ctrl_e_mem, vec_mem[r]);
		check("alu_op_e", alu_op_e, vec_alu[r]);
	endtask

	task automatic check_mem(input int r);
		check("ctrl_m", ctrl_m, vec_mem[r]);
		check("exc_code", exc_code, vec_exc[r]);
		check("exc_pending", exc_pending, vec_exc[r] != exc_none);
	endtask

	task automatic check_idle();
		check("ctrl_e", ctrl_e, '0);
		check("ctrl_e_mem", ctrl_e_mem, '0);
		check("alu_op_e", alu_op_e, alu_nop);
		check("ctrl_m", ctrl_m, '0);
		check("exc_code", exc_code, exc_none);
		check("exc_pending", exc_pending, 1'b0);
	endtask

	// sampled at the falling edge before the next word goes in
	task automatic run_seq();
		int k;
		for (k = 0; k < seq_len + 2; k++) begin
			@(negedge clk);
			if (k >= 1 && k <= seq_len)
				check_exec(seq[k-1]);
			if (k >= 2)
				check_mem(seq[k-2]);
			if (k < seq_len) begin
				instr = vec_instr[seq[k]];
				#1;
				check("sign_ext", sign_ext, vec_sext[seq[k]]); // before any edge
			end
		end
	endtask

	task automatic stall_hold();
		int c;
		@(negedge clk);
		instr = vec_instr[r_add];
		@(negedge clk);
		instr = vec_instr[r_lw];
		@(negedge clk);
		stall_e = 1'b1;
		stall_m = 1'b1;
		instr   = vec_instr[r_sys];
		for (c = 0; c < 3; c++) begin
			@(negedge clk);
			check_exec(r_lw);
			check_mem(r_add);
		end
		stall_e = 1'b0;
		stall_m = 1'b0;
		@(negedge clk);
		check_exec(r_sys);
		check_mem(r_lw);
	endtask

	task automatic flush_stages();
		instr = vec_instr[r_addi];
		@(negedge clk);
		flush_e = 1'b1; // with its stall also set
		stall_e = 1'b1;
		instr   = vec_instr[r_mtc0];
		@(negedge clk);
		check("ctrl_e", ctrl_e, '0);
		check("ctrl_e_mem", ctrl_e_mem, '0);
		check("alu_op_e", alu_op_e, alu_nop);
		check_mem(r_addi);
		flush_e = 1'b0;
		stall_e = 1'b0;
		flush_m = 1'b1;
		stall_m = 1'b1;
		instr   = vec_instr[r_eret];
		@(negedge clk);
		check_exec(r_eret);
		check("ctrl_m", ctrl_m, '0);
		check("exc_code", exc_code, exc_none);
		check("exc_pending", exc_pending, 1'b0);
		flush_m = 1'b0;
		stall_m = 1'b0;
		@(negedge clk);
		check_mem(r_eret);
	endtask

	initial begin
		int wait_n;
		int i;
		int r;
		instr   = '0;
		stall_e = 1'b0;
		stall_m = 1'b0;
		flush_e = 1'b0;
		flush_m = 1'b0;
		lfsr    = 16'd87;
		load_table();

		wait_n = 0;
		while (rst_n !== 1'b1) begin
			#1;
			wait_n++;
			if (wait_n > 200)
				abort_run("timed out waiting for reset release");
		end
		check_idle(); // no edge since release yet

		for (i = 0; i < n_rows; i++)
			seq[i] = i;
		seq_len = n_rows;
		run_seq();

		for (i = 0; i < 40; i++) begin
			pick_row(r);
			seq[i] = r;
		end
		seq_len = 40;
		run_seq();

		stall_hold();
		flush_stages();

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* mips_ctrl.f */
+incdir+tb
hw/mips_ctrl_pkg.sv
hw/main_decoder.sv
hw/alu_decoder.sv
hw/exc_encoder.sv
hw/ctrl_unit.sv
tb/tb_ctrl_unit.sv
